// ==== include/rs_macros.svh ====
`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// register and rob tag widths
`define PHYS_REG_W 6
`define ARCH_REG_W 5
`define ROB_IDX_W  6

// slot counts per station
`define ADD_RS_DEPTH 8
`define MUL_RS_DEPTH 4
`define DIV_RS_DEPTH 4

`endif

// ==== logic/rv_types_pkg.sv ====
`default_nettype none

`include "rs_macros.svh"

package rv_types_pkg;

    typedef logic [`PHYS_REG_W-1:0] phys_reg_t;  // renamed register tag
    typedef logic [`ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;

    // alt bit (sub / sra) on top of funct3
    typedef logic [3:0] alu_op_t;

    // funct3[1:0] of the M-extension multiplies
    typedef enum logic [1:0] {
        MUL_MUL    = 2'd0,
        MUL_MULH   = 2'd1,
        MUL_MULHSU = 2'd2,
        MUL_MULHU  = 2'd3
    } mul_op_t;

    // funct3[1:0] of the M-extension divides
    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } div_op_t;

endpackage

`default_nettype wire

// ==== logic/rs_pkg.sv ====
`default_nettype none

package rs_pkg;
    import rv_types_pkg::*;

    typedef enum logic [1:0] {
        UNIT_ADD = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_t;

    // register fields carried from rename to issue, 29 bits
    typedef struct packed {
        phys_reg_t ps1;
        phys_reg_t ps2;
        phys_reg_t pd;
        arch_reg_t rd;
        rob_idx_t  rob;
    } reg_set_t;

    typedef struct packed {
        logic       m_ext;      // funct7 bit 0 on an OP instruction
        logic       alt;
        logic [2:0] funct3;
        logic       ps1_ready;
        logic       ps2_ready;
        reg_set_t   regs;
    } dispatch_t;

    // one result tag per cycle
    typedef struct packed {
        logic      valid;
        phys_reg_t tag;
    } cdb_t;

    typedef struct packed {
        reg_set_t regs;
        alu_op_t  op;
    } add_issue_t;

    typedef struct packed {
        reg_set_t regs;
        mul_op_t  op;
    } mul_issue_t;

    typedef struct packed {
        reg_set_t regs;
        div_op_t  op;
    } div_issue_t;

endpackage

`default_nettype wire

// ==== logic/rs_priority_pick.sv ====
`default_nettype none

module rs_priority_pick #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0]         bits,
    output logic                     found,
    output logic [$clog2(WIDTH)-1:0] index
);

    localparam int IDX_W = $clog2(WIDTH);

    // walk down from the top so the lowest set bit is written last
    always_comb
    begin
        found = 1'b0;
        index = '0;
        for (int i = WIDTH - 1; i >= 0; i--)
        begin
            if (bits[i])
            begin
                found = 1'b1;
                index = IDX_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_station.sv ====
`default_nettype none

module rs_station
    import rs_pkg::*;
#(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [1:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     insert,
    input  reg_set_t insert_regs,
    input  logic     insert_ready1,
    input  logic     insert_ready2,
    input  payload_t insert_op,
    input  cdb_t     cdb,
    input  logic     fu_busy,
    output logic     full,
    output logic     issue_valid,
    output reg_set_t issue_regs,
    output payload_t issue_op
);

    localparam int IDX_W = $clog2(DEPTH);

    // per-slot control bits
    logic [DEPTH-1:0] busy;
    logic [DEPTH-1:0] rdy1;
    logic [DEPTH-1:0] rdy2;

    // per-slot payload
    reg_set_t regs_q [DEPTH];
    payload_t op_q   [DEPTH];

    cdb_t cdb_q;  // broadcast seen one cycle late

    logic [IDX_W-1:0] free_slot;
    logic             ready_found;
    logic [IDX_W-1:0] ready_slot;

    logic             hold_q;       // unit stalled last cycle
    logic [IDX_W-1:0] hold_slot_q;
    logic [IDX_W-1:0] issue_slot;
    logic             issue_fire;

    rs_priority_pick #(.WIDTH(DEPTH)) free_pick_i (
        .bits  (~busy),
        .found (),
        .index (free_slot)
    );

    rs_priority_pick #(.WIDTH(DEPTH)) ready_pick_i (
        .bits  (busy & rdy1 & rdy2),
        .found (ready_found),
        .index (ready_slot)
    );

    // a stalled issue stays on its slot until the unit takes it
    assign issue_slot  = hold_q ? hold_slot_q : ready_slot;
    assign issue_valid = hold_q | ready_found;
    assign issue_regs  = regs_q[issue_slot];
    assign issue_op    = op_q[issue_slot];
    assign issue_fire  = issue_valid && !fu_busy;

    assign full = &busy;

    always_ff @(posedge clk)
    begin
        if (rst)
            cdb_q.valid <= 1'b0;
        else
            cdb_q.valid <= cdb.valid;
        cdb_q.tag <= cdb.tag;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy        <= '0;
            rdy1        <= '0;
            rdy2        <= '0;
            hold_q      <= 1'b0;
            hold_slot_q <= '0;
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                // only occupied slots listen to the bus
                if (cdb_q.valid && busy[i])
                begin
                    if (regs_q[i].ps1 == cdb_q.tag)
                        rdy1[i] <= 1'b1;
                    if (regs_q[i].ps2 == cdb_q.tag)
                        rdy2[i] <= 1'b1;
                end
            end

            if (insert)
            begin
                busy[free_slot] <= 1'b1;
                rdy1[free_slot] <= insert_ready1;
                rdy2[free_slot] <= insert_ready2;
            end

            if (issue_fire)
                busy[issue_slot] <= 1'b0;  // never the free slot

            hold_q      <= issue_valid && fu_busy;
            hold_slot_q <= issue_slot;
        end
    end

    always_ff @(posedge clk)
    begin
        if (insert)
        begin
            regs_q[free_slot] <= insert_regs;
            op_q[free_slot]   <= insert_op;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rs_dispatch_route.sv ====
`default_nettype none

module rs_dispatch_route
    import rv_types_pkg::*, rs_pkg::*;
(
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    input  logic      add_full,
    input  logic      mul_full,
    input  logic      div_full,
    output logic      dispatch_ready,
    output logic      add_insert,
    output logic      mul_insert,
    output logic      div_insert,
    output alu_op_t   add_op,
    output mul_op_t   mul_op,
    output div_op_t   div_op
);

    unit_t unit;
    logic  sel_full;
    logic  accept;

    // funct3[2] splits mul* from div/rem
    always_comb
    begin
        if (!dispatch.m_ext)
            unit = UNIT_ADD;
        else if (dispatch.funct3[2])
            unit = UNIT_DIV;
        else
            unit = UNIT_MUL;
    end

    always_comb
    begin
        case (unit)
            UNIT_MUL: sel_full = mul_full;
            UNIT_DIV: sel_full = div_full;
            default:  sel_full = add_full;
        endcase
    end

    assign dispatch_ready = !sel_full;  // only the target station matters
    assign accept         = dispatch_valid && dispatch_ready;

    assign add_insert = accept && (unit == UNIT_ADD);
    assign mul_insert = accept && (unit == UNIT_MUL);
    assign div_insert = accept && (unit == UNIT_DIV);

    assign add_op = {dispatch.alt, dispatch.funct3};
    assign mul_op = mul_op_t'(dispatch.funct3[1:0]);
    assign div_op = div_op_t'(dispatch.funct3[1:0]);

endmodule

`default_nettype wire

// ==== logic/reservation_stations.sv ====
`default_nettype none

`include "rs_macros.svh"

module reservation_stations
    import rv_types_pkg::*, rs_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       dispatch_valid,
    input  dispatch_t  dispatch,
    output logic       dispatch_ready,
    input  cdb_t       cdb,
    input  logic       add_fu_busy,
    input  logic       mul_fu_busy,
    input  logic       div_fu_busy,
    output logic       add_issue_valid,
    output logic       mul_issue_valid,
    output logic       div_issue_valid,
    output add_issue_t add_issue,
    output mul_issue_t mul_issue,
    output div_issue_t div_issue,
    output logic       add_full,
    output logic       mul_full,
    output logic       div_full
);

    logic add_insert;
    logic mul_insert;
    logic div_insert;

    // narrowed ops from the router
    alu_op_t add_op;
    mul_op_t mul_op;
    div_op_t div_op;

    // station outputs before packing
    reg_set_t add_regs;
    reg_set_t mul_regs;
    reg_set_t div_regs;
    alu_op_t  add_issue_op;
    mul_op_t  mul_issue_op;
    div_op_t  div_issue_op;

    rs_dispatch_route route_i (
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .add_full       (add_full),
        .mul_full       (mul_full),
        .div_full       (div_full),
        .dispatch_ready (dispatch_ready),
        .add_insert     (add_insert),
        .mul_insert     (mul_insert),
        .div_insert     (div_insert),
        .add_op         (add_op),
        .mul_op         (mul_op),
        .div_op         (div_op)
    );

    rs_station #(.DEPTH(`ADD_RS_DEPTH), .payload_t(alu_op_t)) add_rs_i (
        .clk (clk), .rst (rst),
        .insert (add_insert), .insert_regs (dispatch.regs),
        .insert_ready1 (dispatch.ps1_ready), .insert_ready2 (dispatch.ps2_ready),
        .insert_op (add_op), .cdb (cdb), .fu_busy (add_fu_busy), .full (add_full),
        .issue_valid (add_issue_valid), .issue_regs (add_regs), .issue_op (add_issue_op)
    );

    rs_station #(.DEPTH(`MUL_RS_DEPTH), .payload_t(mul_op_t)) mul_rs_i (
        .clk (clk), .rst (rst),
        .insert (mul_insert), .insert_regs (dispatch.regs),
        .insert_ready1 (dispatch.ps1_ready), .insert_ready2 (dispatch.ps2_ready),
        .insert_op (mul_op), .cdb (cdb), .fu_busy (mul_fu_busy), .full (mul_full),
        .issue_valid (mul_issue_valid), .issue_regs (mul_regs), .issue_op (mul_issue_op)
    );

    rs_station #(.DEPTH(`DIV_RS_DEPTH), .payload_t(div_op_t)) div_rs_i (
        .clk (clk), .rst (rst),
        .insert (div_insert), .insert_regs (dispatch.regs),
        .insert_ready1 (dispatch.ps1_ready), .insert_ready2 (dispatch.ps2_ready),
        .insert_op (div_op), .cdb (cdb), .fu_busy (div_fu_busy), .full (div_full),
        .issue_valid (div_issue_valid), .issue_regs (div_regs), .issue_op (div_issue_op)
    );

    assign add_issue = '{regs: add_regs, op: add_issue_op};
    assign mul_issue = '{regs: mul_regs, op: mul_issue_op};
    assign div_issue = '{regs: div_regs, op: div_issue_op};

endmodule

`default_nettype wire

// ==== sim/rs_sva.sv ====
`default_nettype none

module rs_sva
    import rs_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     insert,
    input logic     full,
    input logic     fu_busy,
    input logic     issue_valid,
    input reg_set_t issue_regs
);

    timeunit 1ns;
    timeprecision 100ps;

    // the router holds dispatch off a full station
    no_insert_when_full: assert property (@(posedge clk) disable iff (rst) !(insert && full))
        else $error("insert into a full station");

    idle_after_reset: assert property (@(posedge clk) rst |=> !issue_valid)
        else $error("issue_valid high in the cycle after reset");

    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        issue_valid && fu_busy |=> issue_valid && $stable(issue_regs))
        else $error("stalled issue changed while the unit was busy");  // same entry expected

endmodule

bind rs_station rs_sva sva_i (
    .clk         (clk),
    .rst         (rst),
    .insert      (insert),
    .full        (full),
    .fu_busy     (fu_busy),
    .issue_valid (issue_valid),
    .issue_regs  (issue_regs)
);

`default_nettype wire

// ==== sim/tb_reservation_stations.sv ====
`default_nettype none

`include "rs_macros.svh"

module tb_reservation_stations
    import rv_types_pkg::*, rs_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_READY    = 40;
    localparam int N_WAIT     = 6;
    localparam int N_FILL     = `ADD_RS_DEPTH + `MUL_RS_DEPTH + `DIV_RS_DEPTH;
    localparam int N_STALL    = 60;
    localparam int N_DISPATCH = N_READY + N_WAIT + N_FILL + N_STALL;
    localparam int ROBS       = 2 ** `ROB_IDX_W;
    localparam int NEVER      = 32'h7fff_ffff;

    logic       clk = 1'b0;
    logic       rst;
    logic       dispatch_valid;
    dispatch_t  dispatch;
    logic       dispatch_ready;
    cdb_t       cdb;
    logic       add_fu_busy = 1'b0;
    logic       mul_fu_busy = 1'b0;
    logic       div_fu_busy = 1'b0;
    logic       add_issue_valid;
    logic       mul_issue_valid;
    logic       div_issue_valid;
    add_issue_t add_issue;
    mul_issue_t mul_issue;
    div_issue_t div_issue;
    logic       add_full;
    logic       mul_full;
    logic       div_full;

    // scoreboard, one slot per rob index
    logic       pending    [ROBS] = '{default: 1'b0};
    unit_t      exp_unit   [ROBS];
    add_issue_t exp_add    [ROBS];
    mul_issue_t exp_mul    [ROBS];
    div_issue_t exp_div    [ROBS];
    int         release_at [ROBS];  // first edge count where issue is legal

    int        cycle      = 0;
    int        sent       = 0;
    int        issued     = 0;
    logic      stall_mode = 1'b0;
    rob_idx_t  next_rob   = '0;
    phys_reg_t next_tag   = '0;  // tags held back for the cdb

    reservation_stations dut_i (.*);

    initial
    begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // routing rule applied to one dispatch
    function automatic unit_t expected_issue(input dispatch_t d, output add_issue_t a,
                                             output mul_issue_t m, output div_issue_t v);
        a = '{regs: d.regs, op: {d.alt, d.funct3}};
        m = '{regs: d.regs, op: mul_op_t'(d.funct3[1:0])};
        v = '{regs: d.regs, op: div_op_t'(d.funct3[1:0])};
        if (!d.m_ext)
            return UNIT_ADD;
        return d.funct3[2] ? UNIT_DIV : UNIT_MUL;
    endfunction

    function automatic unit_t random_unit();
        return unit_t'($urandom_range(2, 0));
    endfunction

    function automatic dispatch_t random_instr(input unit_t u, input logic r1, input logic r2);
        dispatch_t d;
        d.alt       = 1'($urandom);
        d.funct3    = 3'($urandom);
        d.m_ext     = (u != UNIT_ADD);
        d.ps1_ready = r1;
        d.ps2_ready = r2;
        d.regs.ps1  = phys_reg_t'($urandom);
        d.regs.ps2  = phys_reg_t'($urandom);
        d.regs.pd   = phys_reg_t'($urandom);
        d.regs.rd   = arch_reg_t'($urandom);
        d.regs.rob  = next_rob;
        next_rob++;
        if (u != UNIT_ADD)
            d.funct3[2] = (u == UNIT_DIV);  // mul vs div/rem
        if (!r1)
        begin
            d.regs.ps1 = next_tag;
            next_tag++;
        end
        if (!r2)
        begin
            d.regs.ps2 = next_tag;
            next_tag++;
        end
        return d;
    endfunction

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_with($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_slot(input rob_idx_t r, input unit_t u);
        if (!pending[r])
            fail_with($sformatf("rob %0d issued while not waiting to issue", r));
        if (exp_unit[r] != u)
            fail_with($sformatf("Mismatch issue unit of rob %h: got %h expected %h",
                                r, u, exp_unit[r]));
        if (cycle < release_at[r])
            fail_with($sformatf("rob %0d issued before its source tag was woken", r));
        pending[r] <= 1'b0;
    endtask

    task automatic check_add_issue(input add_issue_t got);
        check_slot(got.regs.rob, UNIT_ADD);
        if (got !== exp_add[got.regs.rob])
            fail_with($sformatf("Mismatch add_issue: got %h expected %h",
                                got, exp_add[got.regs.rob]));
    endtask

    task automatic check_mul_issue(input mul_issue_t got);
        check_slot(got.regs.rob, UNIT_MUL);
        if (got !== exp_mul[got.regs.rob])
            fail_with($sformatf("Mismatch mul_issue: got %h expected %h",
                                got, exp_mul[got.regs.rob]));
    endtask

    task automatic check_div_issue(input div_issue_t got);
        check_slot(got.regs.rob, UNIT_DIV);
        if (got !== exp_div[got.regs.rob])
            fail_with($sformatf("Mismatch div_issue: got %h expected %h",
                                got, exp_div[got.regs.rob]));
    endtask

    // completed issues, seen where valid meets a free unit
    always @(posedge clk)
    begin
        int n;
        n = 0;
        if (!rst)
        begin
            if (add_issue_valid && !add_fu_busy)
            begin
                check_add_issue(add_issue);
                n++;
            end
            if (mul_issue_valid && !mul_fu_busy)
            begin
                check_mul_issue(mul_issue);
                n++;
            end
            if (div_issue_valid && !div_fu_busy)
            begin
                check_div_issue(div_issue);
                n++;
            end
            issued <= issued + n;
        end
    end

    always @(posedge clk)
    begin
        if (stall_mode)
        begin
            add_fu_busy <= 1'($urandom);
            mul_fu_busy <= 1'($urandom);
            div_fu_busy <= 1'($urandom);
        end
        else
        begin
            add_fu_busy <= 1'b0;
            mul_fu_busy <= 1'b0;
            div_fu_busy <= 1'b0;
        end
    end

    // drives one dispatch and logs it once the handshake completes
    task automatic send(input dispatch_t d);
        unit_t      u;
        add_issue_t a;
        mul_issue_t m;
        div_issue_t v;
        u = expected_issue(d, a, m, v);
        if (pending[d.regs.rob])
            fail_with($sformatf("rob %0d reused while still in a station", d.regs.rob));
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        do
            @(posedge clk);
        while (!dispatch_ready);
        pending[d.regs.rob]    <= 1'b1;
        exp_unit[d.regs.rob]   <= u;
        exp_add[d.regs.rob]    <= a;
        exp_mul[d.regs.rob]    <= m;
        exp_div[d.regs.rob]    <= v;
        release_at[d.regs.rob] <= (d.ps1_ready && d.ps2_ready) ? 0 : NEVER;
        sent++;
    endtask

    // one tag per cycle, issue legal three edges after the drive edge
    task automatic wake_all(input dispatch_t waiting[$]);
        foreach (waiting[i])
        begin
            cdb <= '{valid: 1'b1,
                     tag: waiting[i].ps1_ready ? waiting[i].regs.ps2 : waiting[i].regs.ps1};
            release_at[waiting[i].regs.rob] <= cycle + 3;
            @(posedge clk);
        end
        cdb <= '0;
    endtask

    task automatic wait_drained();
        while (issued != sent)
            @(posedge clk);
    endtask

    task automatic fill_and_drain(input unit_t u, input int depth);
        dispatch_t held[$];
        dispatch_t d;
        for (int i = 0; i < depth; i++)
        begin
            d = random_instr(u, 1'b0, 1'b1);
            send(d);
            held.push_back(d);
        end
        dispatch_valid <= 1'b0;
        dispatch       <= random_instr(u, 1'b1, 1'b1);  // probe only, never sent
        @(posedge clk);
        check_flag("add_full", add_full, u == UNIT_ADD);
        check_flag("mul_full", mul_full, u == UNIT_MUL);
        check_flag("div_full", div_full, u == UNIT_DIV);
        check_flag("dispatch_ready", dispatch_ready, 1'b0);
        dispatch <= random_instr(unit_t'((int'(u) + 1) % 3), 1'b1, 1'b1);
        @(posedge clk);
        check_flag("dispatch_ready", dispatch_ready, 1'b1);
        wake_all(held);
        wait_drained();
    endtask

    initial
    begin
        dispatch_t held[$];
        dispatch_t d;
        void'($urandom(32'h79b4));
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        cdb            = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_flag("add_issue_valid", add_issue_valid, 1'b0);
        check_flag("mul_issue_valid", mul_issue_valid, 1'b0);
        check_flag("div_issue_valid", div_issue_valid, 1'b0);
        check_flag("add_full", add_full, 1'b0);
        check_flag("mul_full", mul_full, 1'b0);
        check_flag("div_full", div_full, 1'b0);
        check_flag("dispatch_ready", dispatch_ready, 1'b1);

        for (int i = 0; i < N_READY; i++)
            send(random_instr(random_unit(), 1'b1, 1'b1));
        dispatch_valid <= 1'b0;
        wait_drained();

        // one source held back, alternating between ps1 and ps2
        for (int i = 0; i < N_WAIT; i++)
        begin
            d = random_instr(unit_t'(i % 3), i[0], !i[0]);
            send(d);
            held.push_back(d);
        end
        dispatch_valid <= 1'b0;
        repeat (8) @(posedge clk);
        wake_all(held);
        wait_drained();

        fill_and_drain(UNIT_ADD, `ADD_RS_DEPTH);
        fill_and_drain(UNIT_MUL, `MUL_RS_DEPTH);
        fill_and_drain(UNIT_DIV, `DIV_RS_DEPTH);

        stall_mode <= 1'b1;
        for (int i = 0; i < N_STALL; i++)
            send(random_instr(random_unit(), 1'b1, 1'b1));
        dispatch_valid <= 1'b0;
        stall_mode     <= 1'b0;
        wait_drained();

        repeat (5) @(posedge clk);
        if (issued == sent && !add_issue_valid && !mul_issue_valid && !div_issue_valid)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
            fail_with("instructions left in a station after the last test");
    end

    initial
    begin
        repeat (N_DISPATCH * 20 + 200) @(posedge clk);
        fail_with("timeout, the dispatched instructions did not all issue");
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
logic/rv_types_pkg.sv
logic/rs_pkg.sv
logic/rs_priority_pick.sv
logic/rs_station.sv
logic/rs_dispatch_route.sv
logic/reservation_stations.sv
sim/rs_sva.sv
sim/tb_reservation_stations.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_reservation_stations
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
